// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       = histTb
FILELIST  = src.f
BUILDDIR  = obj_dir

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove build output"
	@echo "make help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILDDIR)
	./$(BUILDDIR)/V$(TOP)

clean:
	rm -rf $(BUILDDIR)

// ==== rtl/floorFinder.sv ====
module floorFinder (
    input  logic           clk,
    input  logic           res,
    scanBus.sink           scan,
    output histPkg::countT floorCount
);

    logic firstBeat;
    logic takeBeat;

    assign firstBeat = (scan.bin == '0);   // bin 0 opens every scan

    // restart on first beat, otherwise only on a smaller count
    assign takeBeat = scan.valid && (firstBeat || scan.count < floorCount);

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            floorCount <= '0;
        end else if (takeBeat) begin
            floorCount <= scan.count;
        end
    end

endmodule

// ==== rtl/histCtrl.sv ====
module histCtrl (
    input  logic          clk,
    input  logic          res,
    input  logic          start,
    input  logic          stop,
    input  logic          stampValid,
    input  histPkg::stampT stamp,
    output logic          acqOpen,
    output logic          busy,
    scanBus.source        scan
);

    histPkg::ctrlStateT state;
    histPkg::ctrlStateT nextState;

    histPkg::binT   addrCnt;     // clear and scan address
    logic           drainCnt;
    histPkg::binT   stampBin;

    // hit stage, read issued the cycle before
    logic           hitValid;
    histPkg::binT   hitBin;

    // copy of the last write for forwarding
    logic           fwdValid;
    histPkg::binT   fwdBin;
    histPkg::countT fwdCount;

    logic           we;
    histPkg::binT   waddr;
    histPkg::countT wdata;
    histPkg::binT   raddr;
    histPkg::countT rdata;
    histPkg::countT baseCount;
    histPkg::countT incCount;

    logic           scanValid;
    logic           scanLast;
    histPkg::binT   scanBin;
    logic           lastDly;
    logic           endBin;

    histRam ram (
        .clk   (clk),
        .we    (we),
        .waddr (waddr),
        .wdata (wdata),
        .raddr (raddr),
        .rdata (rdata)
    );

    assign stampBin = stamp[histPkg::StampWidth-1 -: histPkg::BinWidth];
    assign endBin   = (addrCnt == histPkg::binT'(histPkg::BinCount - 1));
    assign acqOpen  = (state == histPkg::Acquire);

    // previous hit on the same bin is not in the RAM yet
    assign baseCount = (fwdValid && fwdBin == hitBin) ? fwdCount : rdata;
    assign incCount  = (&baseCount) ? baseCount : baseCount + 1'b1;   // hold at max

    assign we    = (state == histPkg::Clear) || hitValid;
    assign waddr = (state == histPkg::Clear) ? addrCnt : hitBin;
    assign wdata = (state == histPkg::Clear) ? '0 : incCount;
    assign raddr = (state == histPkg::Scan) ? addrCnt : stampBin;

    always_comb begin
        nextState = state;
        case (state)
            histPkg::Idle:    if (start && !busy) nextState = histPkg::Clear;
            histPkg::Clear:   if (endBin) nextState = histPkg::Acquire;
            histPkg::Acquire: if (stop) nextState = histPkg::Drain;
            histPkg::Drain:   if (drainCnt) nextState = histPkg::Scan;
            histPkg::Scan:    if (endBin) nextState = histPkg::Idle;
            default:          nextState = histPkg::Idle;
        endcase
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state    <= histPkg::Idle;
            addrCnt  <= '0;
            drainCnt <= 1'b0;
            busy     <= 1'b0;
            lastDly  <= 1'b0;
        end else begin
            state   <= nextState;
            lastDly <= scanLast;
            if (state == histPkg::Idle && start && !busy) begin
                busy <= 1'b1;
            end else if (lastDly) begin
                busy <= 1'b0;   // falls together with done
            end
            if (state == histPkg::Clear || state == histPkg::Scan) begin
                addrCnt <= addrCnt + 1'b1;   // wraps to 0 after bin 63
            end
            drainCnt <= (state == histPkg::Drain) ? ~drainCnt : 1'b0;
        end
    end

    // read-modify-write pipeline
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            hitValid <= 1'b0;
            fwdValid <= 1'b0;
        end else begin
            hitValid <= acqOpen && stampValid;
            fwdValid <= we;
        end
    end

    always_ff @(posedge clk) begin
        hitBin   <= stampBin;
        fwdBin   <= waddr;
        fwdCount <= wdata;
    end

    // scan beat lines up with the RAM read data
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            scanValid <= 1'b0;
            scanLast  <= 1'b0;
        end else begin
            scanValid <= (state == histPkg::Scan);
            scanLast  <= (state == histPkg::Scan) && endBin;
        end
    end

    always_ff @(posedge clk) begin
        scanBin <= addrCnt;
    end

    assign scan.valid = scanValid;
    assign scan.last  = scanLast;
    assign scan.bin   = scanBin;
    assign scan.count = rdata;

    noWriteInScan: assert property (
        @(posedge clk) disable iff (!res) (state == histPkg::Scan) |-> !we
    );

    // stream stops right after the final bin
    lastWithValid: assert property (
        @(posedge clk) disable iff (!res) scan.last |-> scan.valid ##1 !scan.valid
    );

endmodule

// ==== rtl/histPkg.sv ====
package histPkg;

    // histogram geometry
    localparam int BinWidth   = 6;
    localparam int BinCount   = 1 << BinWidth;   // 64 bins
    localparam int CountWidth = 8;               // saturates at 255
    localparam int StampWidth = 10;              // bin = upper BinWidth bits

    // minimum peak-to-floor contrast for a detection
    localparam int ContrastMin = 4;

    typedef logic [BinWidth-1:0]   binT;
    typedef logic [CountWidth-1:0] countT;
    typedef logic [StampWidth-1:0] stampT;

    // controller phases
    typedef enum logic [2:0] {
        Idle,
        Clear,     // zero all bins
        Acquire,   // window open, read-modify-write per stamp
        Drain,     // let pending writes land
        Scan       // stream bins out
    } ctrlStateT;

endpackage

// ==== rtl/histRam.sv ====
module histRam (
    input  logic           clk,
    input  logic           we,
    input  histPkg::binT   waddr,
    input  histPkg::countT wdata,
    input  histPkg::binT   raddr,
    output histPkg::countT rdata
);

    histPkg::countT mem [histPkg::BinCount];

    // write port
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // registered read, returns the old value on a same-cycle write
    always_ff @(posedge clk) begin
        rdata <= mem[raddr];
    end

endmodule

// ==== rtl/histTop.sv ====
module histTop (
    input  logic           clk,
    input  logic           res,
    input  logic           start,
    input  logic           stop,
    input  logic           stampValid,
    input  histPkg::stampT stamp,
    output logic           acqOpen,
    output logic           busy,
    output logic           done,
    output logic           detected,
    output histPkg::binT   peakBin,
    output histPkg::countT peakCount,
    output histPkg::countT floorCount
);

    scanBus scanIf ();

    histPkg::binT   runPeakBin;     // running values from the finders
    histPkg::countT runPeakCount;
    histPkg::countT runFloorCount;

    histCtrl ctrl (
        .clk        (clk),
        .res        (res),
        .start      (start),
        .stop       (stop),
        .stampValid (stampValid),
        .stamp      (stamp),
        .acqOpen    (acqOpen),
        .busy       (busy),
        .scan       (scanIf.source)
    );

    peakFinder peak (
        .clk       (clk),
        .res       (res),
        .scan      (scanIf.sink),
        .peakBin   (runPeakBin),
        .peakCount (runPeakCount)
    );

    floorFinder floor (
        .clk        (clk),
        .res        (res),
        .scan       (scanIf.sink),
        .floorCount (runFloorCount)
    );

    rangeResult result (
        .clk          (clk),
        .res          (res),
        .scan         (scanIf.sink),
        .peakBinIn    (runPeakBin),
        .peakCountIn  (runPeakCount),
        .floorCountIn (runFloorCount),
        .done         (done),
        .detected     (detected),
        .peakBin      (peakBin),
        .peakCount    (peakCount),
        .floorCount   (floorCount)
    );

endmodule

// ==== rtl/peakFinder.sv ====
module peakFinder (
    input  logic           clk,
    input  logic           res,
    scanBus.sink           scan,
    output histPkg::binT   peakBin,
    output histPkg::countT peakCount
);

    logic firstBeat;
    logic takeBeat;

    assign firstBeat = (scan.bin == '0);

    // strictly greater only, so the lowest bin keeps a tie
    assign takeBeat = scan.valid && (firstBeat || scan.count > peakCount);

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            peakBin   <= '0;
            peakCount <= '0;
        end else if (takeBeat) begin
            peakBin   <= scan.bin;
            peakCount <= scan.count;
        end
    end

endmodule

// ==== rtl/rangeResult.sv ====
module rangeResult (
    input  logic           clk,
    input  logic           res,
    scanBus.sink           scan,
    input  histPkg::binT   peakBinIn,
    input  histPkg::countT peakCountIn,
    input  histPkg::countT floorCountIn,
    output logic           done,
    output logic           detected,
    output histPkg::binT   peakBin,
    output histPkg::countT peakCount,
    output histPkg::countT floorCount
);

    logic           lastSeen;   // finders hold the final beat now
    histPkg::countT contrast;

    assign contrast = peakCountIn - floorCountIn;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            lastSeen   <= 1'b0;
            done       <= 1'b0;
            detected   <= 1'b0;
            peakBin    <= '0;
            peakCount  <= '0;
            floorCount <= '0;
        end else begin
            lastSeen <= scan.valid && scan.last;
            done     <= lastSeen;
            if (lastSeen) begin
                detected   <= (contrast >= histPkg::countT'(histPkg::ContrastMin));
                peakBin    <= peakBinIn;
                peakCount  <= peakCountIn;
                floorCount <= floorCountIn;
            end
        end
    end

    floorBelowPeak: assert property (
        @(posedge clk) disable iff (!res) lastSeen |-> (floorCountIn <= peakCountIn)
    );

endmodule

// ==== rtl/scanBus.sv ====
interface scanBus;

    logic          valid;   // one strobe per bin
    logic          last;    // with the beat of the final bin
    histPkg::binT   bin;
    histPkg::countT count;

    modport source (
        output valid,
        output last,
        output bin,
        output count
    );

    modport sink (
        input valid,
        input last,
        input bin,
        input count
    );

endinterface

// ==== src.f ====
rtl/histPkg.sv
rtl/scanBus.sv
rtl/histRam.sv
rtl/histCtrl.sv
rtl/peakFinder.sv
rtl/floorFinder.sv
rtl/rangeResult.sv
rtl/histTop.sv
verification/histTb.sv

// ==== verification/histTb.sv ====
module histTb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int ClkPeriod      = 20;
    localparam int StrobeCount    = 1200;   // upper bound over all tests
    localparam int RunCount       = 8;
    localparam int WatchdogCycles = 2 * StrobeCount + 200 * RunCount;

    logic           clk;
    logic           res;
    logic           start;
    logic           stop;
    logic           stampValid;
    histPkg::stampT stamp;
    logic           acqOpen;
    logic           busy;
    logic           done;
    logic           detected;
    histPkg::binT   peakBin;
    histPkg::countT peakCount;
    histPkg::countT floorCount;

    integer seed = 32'hc1e1;
    int     refHist [histPkg::BinCount];   // reference histogram

    histTop dut (.*);

    initial begin
        clk = 1'b0;
        forever #(ClkPeriod / 2) clk = ~clk;
    end

    initial begin
        #(WatchdogCycles * ClkPeriod);
        $display("Test failed");
        $fatal(1, "timeout, the DUT did not finish the test sequence in time");
    end

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAIL %s: got 0x%0h, expected 0x%0h", name, got, exp);
            $display("Test failed");
            $fatal(1, "check on %s did not match", name);
        end
    endtask

    function automatic histPkg::stampT makeStamp(input histPkg::binT b);
        logic [31:0] r;
        r = $random(seed);
        return {b, r[3:0]};   // random fine time inside the bin
    endfunction

    task automatic addHit(input histPkg::binT b);
        if (refHist[b] < 255)
            refHist[b]++;
    endtask

    task automatic sendStamp(input histPkg::stampT s, input bit inWindow);
        @(negedge clk);
        stampValid = 1'b1;
        stamp      = s;
        checkValue("acqOpen", 32'(acqOpen), 32'(inWindow));
        if (inWindow)
            addHit(s[histPkg::StampWidth-1 -: histPkg::BinWidth]);
    endtask

    task automatic pause(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            stampValid = 1'b0;
        end
    endtask

    // start pulse, optional stamps while the clear runs
    task automatic startRun(input bit hitsInClear, input histPkg::binT clearBin);
        @(negedge clk);
        start      = 1'b1;
        stampValid = 1'b0;
        @(negedge clk);
        start = 1'b0;
        checkValue("busy", 32'(busy), 1);
        while (!acqOpen) begin
            stampValid = hitsInClear;   // window still shut
            stamp      = makeStamp(clearBin);
            @(negedge clk);
        end
        stampValid = 1'b0;
        foreach (refHist[i])
            refHist[i] = 0;
    endtask

    task automatic stopRun(input bit withStamp, input histPkg::binT b);
        @(negedge clk);
        stop       = 1'b1;
        stampValid = withStamp;   // same-cycle stamp still counts
        stamp      = makeStamp(b);
        checkValue("acqOpen", 32'(acqOpen), 1);
        if (withStamp)
            addHit(b);
        @(negedge clk);
        stop       = 1'b0;
        stampValid = 1'b0;
        checkValue("acqOpen", 32'(acqOpen), 0);
    endtask

    task automatic checkResults();
        int expPeak;
        int expBin;
        int expFloor;
        bit expDet;
        expPeak  = refHist[0];
        expBin   = 0;
        expFloor = refHist[0];
        for (int i = 1; i < histPkg::BinCount; i++) begin
            if (refHist[i] > expPeak) begin   // strictly greater keeps lowest bin
                expPeak = refHist[i];
                expBin  = i;
            end
            if (refHist[i] < expFloor)
                expFloor = refHist[i];
        end
        expDet = (expPeak - expFloor) >= histPkg::ContrastMin;
        @(negedge clk);
        while (!done)
            @(negedge clk);
        checkValue("peakBin", 32'(peakBin), expBin);
        checkValue("peakCount", 32'(peakCount), expPeak);
        checkValue("floorCount", 32'(floorCount), expFloor);
        checkValue("detected", 32'(detected), 32'(expDet));
        checkValue("busy", 32'(busy), 0);
        @(negedge clk);
        checkValue("done", 32'(done), 0);   // single-cycle strobe
    endtask

    task automatic singleBinTest();
        startRun(1'b0, '0);
        for (int i = 0; i < 10; i++) begin
            sendStamp(makeStamp(6'd17), 1'b1);
            pause(i % 2);
        end
        stopRun(1'b0, '0);
        checkResults();
        checkValue("peakBin", 32'(peakBin), 17);
        checkValue("peakCount", 32'(peakCount), 10);
    endtask

    task automatic forwardingTest();
        int seq [14] = '{30, 30, 30, 31, 30, 31, 31, 30, 30, 30, 31, 31, 31, 30};
        startRun(1'b0, '0);
        foreach (seq[i])
            sendStamp(makeStamp(histPkg::binT'(seq[i])), 1'b1);
        pause(1);
        sendStamp(makeStamp(6'd31), 1'b1);
        stopRun(1'b1, 6'd31);   // back to back with the hit above
        checkResults();
    endtask

    // fewer hits than before, so leftovers would win the peak
    task automatic clearTest();
        startRun(1'b0, '0);
        repeat (4) begin   // contrast right at the threshold
            sendStamp(makeStamp(6'd5), 1'b1);
            pause(2);
        end
        stopRun(1'b0, '0);
        checkResults();
        checkValue("peakBin", 32'(peakBin), 5);
        checkValue("peakCount", 32'(peakCount), 4);
    endtask

    task automatic windowTest();
        repeat (5) sendStamp(makeStamp(6'd40), 1'b0);
        startRun(1'b1, 6'd40);
        repeat (5) sendStamp(makeStamp(6'd20), 1'b1);
        @(negedge clk);
        stampValid = 1'b0;
        start      = 1'b1;   // ignored while busy
        @(negedge clk);
        start = 1'b0;
        checkValue("acqOpen", 32'(acqOpen), 1);
        stopRun(1'b0, '0);
        repeat (10) sendStamp(makeStamp(6'd40), 1'b0);   // drain and scan
        @(negedge clk);
        stampValid = 1'b0;
        start      = 1'b1;
        @(negedge clk);
        start = 1'b0;
        checkResults();
        checkValue("peakBin", 32'(peakBin), 20);
        checkValue("peakCount", 32'(peakCount), 5);
        repeat (3) @(negedge clk);
        checkValue("busy", 32'(busy), 0);
    endtask

    task automatic saturationTest();
        startRun(1'b0, '0);
        for (int i = 0; i < 400; i++)
            sendStamp(makeStamp((i % 4 == 3) ? 6'd10 : 6'd50), 1'b1);
        stopRun(1'b0, '0);
        checkResults();
        checkValue("peakCount", 32'(peakCount), 255);
        // equal maxima, lower bin reported
        startRun(1'b0, '0);
        for (int i = 0; i < 14; i++)
            sendStamp(makeStamp((i % 2 == 0) ? 6'd44 : 6'd12), 1'b1);
        stopRun(1'b0, '0);
        checkResults();
        checkValue("peakBin", 32'(peakBin), 12);
    endtask

    task automatic randomTest();
        logic [31:0] r;
        startRun(1'b0, '0);
        for (int i = 0; i < 400; i++) begin
            r = $random(seed);
            if (r[31:29] == 3'd0)
                pause(1);
            sendStamp(r[9:0], 1'b1);
        end
        stopRun(1'b0, '0);
        checkResults();
        // nearly flat, contrast too small for a detection
        startRun(1'b0, '0);
        for (int b = 0; b < histPkg::BinCount; b++) begin
            repeat (3) sendStamp(makeStamp(histPkg::binT'(b)), 1'b1);
        end
        repeat (3) begin
            r = $random(seed);
            sendStamp(makeStamp(r[5:0]), 1'b1);
        end
        stopRun(1'b0, '0);
        checkResults();
        checkValue("detected", 32'(detected), 0);
    endtask

    initial begin
        res        = 1'b0;
        start      = 1'b0;
        stop       = 1'b0;
        stampValid = 1'b0;
        stamp      = '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        checkValue("acqOpen", 32'(acqOpen), 0);
        checkValue("busy", 32'(busy), 0);
        checkValue("done", 32'(done), 0);
        checkValue("detected", 32'(detected), 0);
        checkValue("peakBin", 32'(peakBin), 0);
        checkValue("peakCount", 32'(peakCount), 0);
        checkValue("floorCount", 32'(floorCount), 0);
        res = 1'b1;
        singleBinTest();
        forwardingTest();
        clearTest();
        windowTest();
        saturationTest();
        randomTest();
        $display("Test passed");
        $finish;
    end

endmodule
